/* dv/tb_vic_vga.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vic_vga;

   localparam int line_buf_depth = 520;
   // cycles allowed for two full vsync pulses
   localparam int run_timeout = 2_700_000;

   logic              clk_dot4x;
   logic              rst;
   vic_pkg::chip_t    chip;
   vic_pkg::color_t   pixel_in;
   vic_pkg::raster_t  raster;
   vga_pkg::vga_out_t vga;

   logic [15:0] lfsr;

   // reference model state
   vga_pkg::vga_timing_t mt;
   int          src_width;
   int          src_lines;
   logic [1:0]  m_ph;
   logic [9:0]  m_x;
   logic [8:0]  m_y;
   logic        m_half;
   logic [9:0]  m_h;
   logic [9:0]  m_v;
   logic        m_hs;
   logic        m_vs;
   logic        m_act;
   logic        m_bank;
   logic [3:0]  m_rd;
   bit          m_rd_known;
   logic [3:0]  line_copy [2][line_buf_depth];
   bit          line_known [2][line_buf_depth];

   // sync measurements
   int   cyc;
   int   hs_fall_at;
   int   vs_fall_at;
   int   vs_pulses;
   int   pixel_checks;
   logic prev_hs;
   logic prev_vs;

   vic_vga_top #(
      .line_buf_depth (line_buf_depth)
   ) vic_vga_top_i (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .pixel_in  (pixel_in),
      .raster    (raster),
      .vga       (vga)
   );

   initial begin
      clk_dot4x = 1'b0;
      forever #50 clk_dot4x = ~clk_dot4x;
   end

   // reference sync layout per chip in vga_timing_t field order
   function automatic vga_pkg::vga_timing_t expected_timing(input vic_pkg::chip_t c);
      vga_pkg::vga_timing_t t;
      case (c)
         vic_pkg::chip_6567r8:
            t = '{10'd519, 10'd525, 10'd10, 10'd72, 10'd103, 10'd512, 10'd515, 10'd502,
                  10'd20, 10'd52};
         vic_pkg::chip_6567r56a:
            t = '{10'd511, 10'd523, 10'd10, 10'd71, 10'd102, 10'd512, 10'd515, 10'd502,
                  10'd20, 10'd52};
         default:
            t = '{10'd503, 10'd623, 10'd10, 10'd70, 10'd100, 10'd580, 10'd583, 10'd569,
                  10'd10, 10'd20};
      endcase
      return t;
   endfunction

   function automatic int source_width(input vic_pkg::chip_t c);
      case (c)
         vic_pkg::chip_6567r8:   return 520;
         vic_pkg::chip_6567r56a: return 512;
         default:                return 504;
      endcase
   endfunction

   function automatic int source_lines(input vic_pkg::chip_t c);
      case (c)
         vic_pkg::chip_6567r8:   return 263;
         vic_pkg::chip_6567r56a: return 262;
         default:                return 312;
      endcase
   endfunction

   // galois lfsr with polynomial x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic drive_random_pixel();
      logic [3:0] bits;
      int         i;
      for (i = 0; i < 4; i++) begin
         bits[i] = lfsr[0];
         lfsr    = lfsr_next(lfsr);
      end
      pixel_in = vic_pkg::color_t'(bits);
   endtask

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
         stop_run("DUT output differs from the reference model");
      end
   endtask

   // model steps on the same edge as the DUT while inputs are stable
   always @(posedge clk_dot4x) begin : model
      logic       dot;
      logic       origin;
      logic       wsel;
      logic [9:0] addr;
      dot    = (m_ph == 2'd3);
      origin = dot && (m_x == 10'd0) && (m_y == 9'd0);
      addr   = m_h - mt.hoffset;
      // previous line comes from the bank not being filled
      if (m_h < mt.hoffset) begin
         m_rd       = vic_pkg::color_black;
         m_rd_known = 1'b1;
      end else begin
         m_rd       = line_copy[~m_bank][addr];
         m_rd_known = line_known[~m_bank][addr];
      end
      if (rst) begin
         m_ph   = 2'd0;
         m_x    = '0;
         m_y    = '0;
         m_half = 1'b0;
         m_h    = '0;
         m_v    = mt.max_height - mt.voffset;
         m_hs   = 1'b1;
         m_vs   = 1'b1;
         m_act  = 1'b0;
         m_bank = 1'b0;
      end else begin
         m_hs  = !((m_h >= mt.hs_sta) && (m_h < mt.hs_end));
         m_vs  = !((m_v >= mt.vs_sta) && (m_v < mt.vs_end));
         m_act = (m_h >= mt.ha_sta) && (m_v < mt.va_end);
         if (dot) begin
            wsel                  = (m_x == 10'd0) ? ~m_bank : m_bank;
            line_copy[wsel][m_x]  = pixel_in;
            line_known[wsel][m_x] = 1'b1;
            m_bank                = wsel;
            if (int'(m_x) == src_width - 1) begin
               m_x = '0;
               m_y = (int'(m_y) == src_lines - 1) ? 9'd0 : m_y + 9'd1;
            end else begin
               m_x = m_x + 10'd1;
            end
         end
         if (m_half) begin
            if (m_h < mt.max_width) begin
               m_h = m_h + 10'd1;
            end else begin
               m_h = '0;
               m_v = (m_v < mt.max_height) ? m_v + 10'd1 : 10'd0;
            end
         end
         m_half = ~m_half;
         // source frame start pins the output frame
         if (origin) begin
            m_v = mt.max_height - mt.voffset;
         end
         m_ph = m_ph + 2'd1;
      end
   end

   task automatic measure_syncs();
      int line_clocks;
      line_clocks = 2 * (int'(mt.max_width) + 1);
      if (prev_hs && !vga.hsync) begin
         if (hs_fall_at >= 0) begin
            check_value("hsync period", cyc - hs_fall_at, line_clocks);
         end
         hs_fall_at = cyc;
      end
      if (!prev_hs && vga.hsync && hs_fall_at >= 0) begin
         check_value("hsync low width", cyc - hs_fall_at,
                     2 * (int'(mt.hs_end) - int'(mt.hs_sta)));
      end
      if (prev_vs && !vga.vsync) begin
         vs_fall_at = cyc;
      end
      if (!prev_vs && vga.vsync && vs_fall_at >= 0) begin
         check_value("vsync low width", cyc - vs_fall_at, 3 * line_clocks);
         vs_pulses++;
      end
      prev_hs = vga.hsync;
      prev_vs = vga.vsync;
   endtask

   // compare at the falling edge and then drive the next dot
   task automatic step_cycle();
      @(negedge clk_dot4x);
      cyc++;
      check_value("raster.x", 32'(raster.x), 32'(m_x));
      check_value("raster.y", 32'(raster.y), 32'(m_y));
      check_value("raster.dot_rising", 32'(raster.dot_rising), 32'(m_ph == 2'd3));
      check_value("vga.hsync", 32'(vga.hsync), 32'(m_hs));
      check_value("vga.vsync", 32'(vga.vsync), 32'(m_vs));
      check_value("vga.active", 32'(vga.active), 32'(m_act));
      if (!vga.active) begin
         check_value("vga.pixel blank", 32'(vga.pixel), 32'(vic_pkg::color_black));
      end else if (m_rd_known) begin
         check_value("vga.pixel", 32'(vga.pixel), 32'(m_rd));
         pixel_checks++;
      end
      measure_syncs();
      if (m_ph == 2'd0) begin
         drive_random_pixel();
      end
   endtask

   task automatic run_chip(input vic_pkg::chip_t c);
      chip      = c;
      rst       = 1'b1;
      mt        = expected_timing(c);
      src_width = source_width(c);
      src_lines = source_lines(c);
      repeat (4) @(negedge clk_dot4x);
      // outputs straight out of reset
      check_value("vga.hsync after reset", 32'(vga.hsync), 32'd1);
      check_value("vga.vsync after reset", 32'(vga.vsync), 32'd1);
      check_value("vga.active after reset", 32'(vga.active), 32'd0);
      check_value("vga.pixel after reset", 32'(vga.pixel), 32'(vic_pkg::color_black));
      rst          = 1'b0;
      cyc          = 0;
      hs_fall_at   = -1;
      vs_fall_at   = -1;
      vs_pulses    = 0;
      pixel_checks = 0;
      prev_hs      = 1'b1;
      prev_vs      = 1'b1;
      while (vs_pulses < 2) begin
         if (cyc >= run_timeout) begin
            stop_run("timeout while waiting for two full vsync pulses");
         end else begin
            step_cycle();
         end
      end
      if (pixel_checks == 0) begin
         stop_run("no visible pixels were compared for this chip model");
      end else begin
         $display("%s done after %0d cycles, %0d pixels compared", c.name(), cyc,
                  pixel_checks);
      end
   endtask

   initial begin
      rst      = 1'b1;
      chip     = vic_pkg::chip_6569;
      pixel_in = vic_pkg::color_black;
      lfsr     = 16'd47292;
      run_chip(vic_pkg::chip_6569);
      run_chip(vic_pkg::chip_6567r8);
      run_chip(vic_pkg::chip_6567r56a);
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
hdl/vic_pkg.sv
hdl/vga_pkg.sv
hdl/vga_timing_regs.sv
hdl/vic_raster.sv
hdl/vga_scan_counter.sv
hdl/line_buffer.sv
hdl/vic_vga_top.sv
dv/tb_vic_vga.sv

/* hdl/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
   parameter int line_buf_depth = 520
) (
   input  wire                  clk_dot4x,
   input  wire                  rst,
   input  vic_pkg::raster_t     raster,
   input  vic_pkg::color_t      pixel_in,
   input  vga_pkg::vga_timing_t timing,
   input  wire  [9:0]           h_count,
   input  vga_pkg::vga_out_t    sync,
   output vga_pkg::vga_out_t    vga
);

   // one bank fills while the other is shown twice
   vic_pkg::color_t bank0 [line_buf_depth];
   vic_pkg::color_t bank1 [line_buf_depth];

   logic            bank;
   logic            wr_sel;
   logic [9:0]      rd_addr;
   vic_pkg::color_t rd_pixel;

   // x 0 already goes into the new bank
   assign wr_sel = (raster.x == 10'd0) ? ~bank : bank;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         bank <= 1'b0;
      end else if (raster.dot_rising) begin
         bank <= wr_sel;
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (raster.dot_rising) begin
         if (wr_sel) begin
            bank1[raster.x] <= pixel_in;
         end else begin
            bank0[raster.x] <= pixel_in;
         end
      end
   end

   assign rd_addr = h_count - timing.hoffset;

   // read the bank that is not being written, lines up with sync
   always_ff @(posedge clk_dot4x) begin
      if (h_count < timing.hoffset) begin
         rd_pixel <= vic_pkg::color_black;
      end else if (bank) begin
         rd_pixel <= bank0[rd_addr];
      end else begin
         rd_pixel <= bank1[rd_addr];
      end
   end

   // blank outside the visible window
   assign vga = '{
      hsync:  sync.hsync,
      vsync:  sync.vsync,
      active: sync.active,
      pixel:  sync.active ? rd_pixel : vic_pkg::color_black
   };

endmodule

`default_nettype wire

/* hdl/vga_pkg.sv */
`default_nettype none

package vga_pkg;

   // doubled output timing, all in output pixels or output lines
   typedef struct packed {
      // last h_count of a line
      logic [9:0] max_width;
      // last v_count of a frame
      logic [9:0] max_height;
      // horizontal sync window [hs_sta, hs_end)
      logic [9:0] hs_sta;
      logic [9:0] hs_end;
      // first visible column
      logic [9:0] ha_sta;
      // vertical sync window [vs_sta, vs_end)
      logic [9:0] vs_sta;
      logic [9:0] vs_end;
      // first line past the visible area
      logic [9:0] va_end;
      // shift of the source line into the output line
      logic [9:0] hoffset;
      // vertical realignment to the source frame
      logic [9:0] voffset;
   } vga_timing_t;

   // one output pixel with its sync, sync is active low
   typedef struct packed {
      logic           hsync;
      logic           vsync;
      logic           active;
      vic_pkg::color_t pixel;
   } vga_out_t;

   // blanked output with both syncs released
   localparam vga_out_t vga_idle = '{
      hsync:  1'b1,
      vsync:  1'b1,
      active: 1'b0,
      pixel:  vic_pkg::color_black
   };

endpackage

`default_nettype wire

/* hdl/vga_scan_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_scan_counter (
   input  wire                  clk_dot4x,
   input  wire                  rst,
   input  vga_pkg::vga_timing_t timing,
   input  vic_pkg::raster_t     raster,
   output logic [9:0]           h_count,
   output logic [9:0]           v_count,
   output vga_pkg::vga_out_t    sync
);

   logic       half;
   logic       at_origin;
   logic [9:0] v_start;
   logic       hs_on;
   logic       vs_on;
   logic       in_view;

   // first dot of a source frame
   assign at_origin = raster.dot_rising && (raster.x == 10'd0) && (raster.y == 9'd0);

   // top of source frame lands voffset lines before the output wraps
   assign v_start = timing.max_height - timing.voffset;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         half    <= 1'b0;
         h_count <= '0;
         v_count <= v_start;
      end else begin
         half <= ~half;
         // output pixels run at twice the dot rate
         if (half) begin
            if (h_count < timing.max_width) begin
               h_count <= h_count + 10'd1;
            end else begin
               h_count <= '0;
               if (v_count < timing.max_height) begin
                  v_count <= v_count + 10'd1;
               end else begin
                  v_count <= '0;
               end
            end
         end
         // realign wins over the normal line step
         if (at_origin) begin
            v_count <= v_start;
         end
      end
   end

   assign hs_on   = (h_count >= timing.hs_sta) && (h_count < timing.hs_end);
   assign vs_on   = (v_count >= timing.vs_sta) && (v_count < timing.vs_end);
   assign in_view = (h_count >= timing.ha_sta) && (v_count < timing.va_end);

   // sync is active low, pixel is filled in by the line buffer
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         sync <= vga_pkg::vga_idle;
      end else begin
         sync <= '{
            hsync:  ~hs_on,
            vsync:  ~vs_on,
            active: in_view,
            pixel:  vic_pkg::color_black
         };
      end
   end

endmodule

`default_nettype wire

/* hdl/vga_timing_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing_regs (
   input  wire                   clk_dot4x,
   input  wire                   rst,
   input  vic_pkg::chip_t        chip,
   output vga_pkg::vga_timing_t  timing
);

   // chip strap is only looked at while in reset, values hold afterwards
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         case (chip)
            vic_pkg::chip_6567r8: begin
               timing.max_width  <= 10'd519;
               timing.max_height <= 10'd525;
               // front porch 10, sync 62, back porch 31
               timing.hs_sta     <= 10'd10;
               timing.hs_end     <= 10'd72;
               timing.ha_sta     <= 10'd103;
               // 526 lines, back porch 11, sync 3, front porch 10
               timing.vs_sta     <= 10'd512;
               timing.vs_end     <= 10'd515;
               timing.va_end     <= 10'd502;
               timing.hoffset    <= 10'd20;
               timing.voffset    <= 10'd52;
            end
            vic_pkg::chip_6567r56a: begin
               timing.max_width  <= 10'd511;
               timing.max_height <= 10'd523;
               // front porch 10, sync 61, back porch 31
               timing.hs_sta     <= 10'd10;
               timing.hs_end     <= 10'd71;
               timing.ha_sta     <= 10'd102;
               // 524 lines, back porch 9, sync 3, front porch 10
               timing.vs_sta     <= 10'd512;
               timing.vs_end     <= 10'd515;
               timing.va_end     <= 10'd502;
               timing.hoffset    <= 10'd20;
               timing.voffset    <= 10'd52;
            end
            default: begin
               // 6569, also used for the unused strap
               timing.max_width  <= 10'd503;
               timing.max_height <= 10'd623;
               // front porch 10, sync 60, back porch 30
               timing.hs_sta     <= 10'd10;
               timing.hs_end     <= 10'd70;
               timing.ha_sta     <= 10'd100;
               // 624 lines, back porch 41, sync 3, front porch 11
               timing.vs_sta     <= 10'd580;
               timing.vs_end     <= 10'd583;
               timing.va_end     <= 10'd569;
               timing.hoffset    <= 10'd10;
               timing.voffset    <= 10'd20;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/vic_pkg.sv */
`default_nettype none

package vic_pkg;

   // chip model strap, same encoding as the chip select pins
   typedef enum logic [1:0] {
      chip_6567r56a = 2'd0,
      chip_6569     = 2'd1,
      chip_6567r8   = 2'd2,
      chip_unused   = 2'd3
   } chip_t;

   // fixed 16 entry palette
   typedef enum logic [3:0] {
      color_black       = 4'd0,
      color_white       = 4'd1,
      color_red         = 4'd2,
      color_cyan        = 4'd3,
      color_purple      = 4'd4,
      color_green       = 4'd5,
      color_blue        = 4'd6,
      color_yellow      = 4'd7,
      color_orange      = 4'd8,
      color_brown       = 4'd9,
      color_pink        = 4'd10,
      color_dark_grey   = 4'd11,
      color_grey        = 4'd12,
      color_light_green = 4'd13,
      color_light_blue  = 4'd14,
      color_light_grey  = 4'd15
   } color_t;

   // native raster position, dot_rising marks the cycle a dot is taken
   typedef struct packed {
      logic [9:0] x;
      logic [8:0] y;
      logic       dot_rising;
   } raster_t;

   // dots per raster line
   function automatic logic [9:0] line_width(chip_t chip);
      case (chip)
         chip_6567r8:   return 10'd520;
         chip_6567r56a: return 10'd512;
         // 6569 and the unused strap
         default:       return 10'd504;
      endcase
   endfunction

   // raster lines per frame
   function automatic logic [8:0] line_count(chip_t chip);
      case (chip)
         chip_6567r8:   return 9'd263;
         chip_6567r56a: return 9'd262;
         default:       return 9'd312;
      endcase
   endfunction

endpackage

`default_nettype wire

/* hdl/vic_raster.sv */
`timescale 1ns/1ps
`default_nettype none

module vic_raster #(
   parameter int line_buf_depth = 520
) (
   input  wire               clk_dot4x,
   input  wire               rst,
   input  vic_pkg::chip_t    chip,
   output vic_pkg::raster_t  raster
);

   localparam logic [9:0] depth_last = 10'(line_buf_depth - 1);

   logic [3:0] phase;
   logic [9:0] x;
   logic [8:0] y;
   logic [9:0] width_last;
   logic [9:0] last_x;
   logic [8:0] last_y;

   // never run x past the end of the line buffer
   assign width_last = vic_pkg::line_width(chip) - 10'd1;
   assign last_x     = (width_last > depth_last) ? depth_last : width_last;
   assign last_y     = vic_pkg::line_count(chip) - 9'd1;

   // one hot phase, bit 3 is the dot cycle
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase <= 4'b0001;
      end else begin
         phase <= {phase[2:0], phase[3]};
      end
   end

   // position holds for the whole dot and steps after dot_rising
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         x <= '0;
         y <= '0;
      end else if (phase[3]) begin
         if (x >= last_x) begin
            x <= '0;
            if (y >= last_y) begin
               y <= '0;
            end else begin
               y <= y + 9'd1;
            end
         end else begin
            x <= x + 10'd1;
         end
      end
   end

   assign raster = '{x: x, y: y, dot_rising: phase[3]};

endmodule

`default_nettype wire

/* hdl/vic_vga_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vic_vga_top #(
   parameter int line_buf_depth = 520
) (
   input  wire               clk_dot4x,
   input  wire               rst,
   input  vic_pkg::chip_t    chip,
   input  vic_pkg::color_t   pixel_in,
   output vic_pkg::raster_t  raster,
   output vga_pkg::vga_out_t vga
);

   vga_pkg::vga_timing_t timing;
   logic [9:0]           h_count;
   vga_pkg::vga_out_t    sync;

   vga_timing_regs vga_timing_regs_i (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .timing    (timing)
   );

   vic_raster #(
      .line_buf_depth (line_buf_depth)
   ) vic_raster_i (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .raster    (raster)
   );

   vga_scan_counter vga_scan_counter_i (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .timing    (timing),
      .raster    (raster),
      .h_count   (h_count),
      .v_count   (),
      .sync      (sync)
   );

   line_buffer #(
      .line_buf_depth (line_buf_depth)
   ) line_buffer_i (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .raster    (raster),
      .pixel_in  (pixel_in),
      .timing    (timing),
      .h_count   (h_count),
      .sync      (sync),
      .vga       (vga)
   );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the video path testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps -f flist.f \
      --top-module tb_vic_vga -o sim_vic_vga; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_vic_vga > "$log" 2>&1
status=$?
cat "$log"

# the log decides the result
if grep -q "TEST FAILED" "$log"; then
   echo "simulation reported a failure"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi
if ! grep -q "TEST PASSED" "$log"; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
